// ==== common/ll_port_pkg.sv ====
package ll_port_pkg;

    // **************************************************
    // Register space types
    // **************************************************
    typedef logic [4:0]  axil_addr_t;                  // Byte address over two 16-byte windows
    typedef logic [31:0] axil_data_t;                  // AXI4-Lite data word
    typedef logic [31:0] count_t;                      // Frame and drop counters

    // **************************************************
    // Register map
    // **************************************************
    localparam axil_addr_t REG_ID     = 5'h00;         // Read-only ID word
    localparam axil_addr_t REG_CTRL   = 5'h04;         // Bit 0 drain enable
    localparam axil_addr_t REG_LEVEL  = 5'h08;         // FIFO fill level
    localparam axil_addr_t REG_FRAMES = 5'h0C;         // Forwarded frames
    localparam axil_addr_t REG_DROPS  = 5'h10;         // Discarded beats

    localparam axil_data_t ID_VALUE   = 32'h4C4C_5031; // "LLP1"

    // Register block FSM serving one transaction at a time
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,                               // Waiting for a request
        ST_WRESP = 2'd1,                               // Holding bvalid
        ST_RDATA = 2'd2                                // Holding rvalid
    } regs_state_t;

endpackage

// ==== common/axis_if.sv ====
`timescale 1ns/1ps

interface axis_if #(
    parameter int DATA_WIDTH = 8
);

    logic [DATA_WIDTH-1:0] tdata;                      // Beat payload
    logic                  tvalid;                     // Source has a beat
    logic                  tready;                     // Sink takes the beat
    logic                  tlast;                      // Last beat of packet

    // Driving side
    modport src (
        output tdata,
        output tvalid,
        output tlast,
        input  tready
    );

    // Receiving side
    modport sink (
        input  tdata,
        input  tvalid,
        input  tlast,
        output tready
    );

endinterface

// ==== verilog/axis_fifo.sv ====
`timescale 1ns/1ps

module axis_fifo #(
    parameter int DATA_WIDTH      = 8,
    parameter int FIFO_ADDR_WIDTH = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [DATA_WIDTH-1:0]    s_axis_tdata,
    input  logic                     s_axis_tvalid,
    input  logic                     s_axis_tlast,
    output logic                     s_axis_tready,
    axis_if.src                      m,
    input  logic                     drain_en,
    output logic [FIFO_ADDR_WIDTH:0] level
);

    localparam int DEPTH = 2 ** FIFO_ADDR_WIDTH;

    logic [DATA_WIDTH:0]      mem [DEPTH];             // {tlast, tdata}
    logic [FIFO_ADDR_WIDTH:0] wr_ptr;                  // Extra bit tells full from empty
    logic [FIFO_ADDR_WIDTH:0] rd_ptr;
    logic [FIFO_ADDR_WIDTH:0] fill;                    // Beats in the RAM only
    logic                     run;                     // Low until out of reset
    logic                     full;
    logic                     empty;
    logic                     push;
    logic                     load;                    // RAM to output stage
    logic                     out_valid;
    logic [DATA_WIDTH-1:0]    out_data;
    logic                     out_last;

    // **************************************************
    // Status
    // **************************************************
    assign fill  = wr_ptr - rd_ptr;
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[FIFO_ADDR_WIDTH] != rd_ptr[FIFO_ADDR_WIDTH]) &&
                   (wr_ptr[FIFO_ADDR_WIDTH-1:0] == rd_ptr[FIFO_ADDR_WIDTH-1:0]);
    assign level = fill + {{FIFO_ADDR_WIDTH{1'b0}}, out_valid}; // Output stage counts too

    assign s_axis_tready = run && !full;
    assign push          = s_axis_tvalid && s_axis_tready;

    // Refill the output stage when it is empty or being drained
    assign load = drain_en && !empty && (!out_valid || m.tready);

    // **************************************************
    // Pointers and output valid
    // **************************************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run       <= 1'b0;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            out_valid <= 1'b0;
        end else begin
            run <= 1'b1;                               // Accept input after reset
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (load) begin
                rd_ptr    <= rd_ptr + 1'b1;
                out_valid <= 1'b1;
            end else if (m.tvalid && m.tready) begin
                out_valid <= 1'b0;                     // Stage emptied
            end
        end
    end

    // Storage and output payload
    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr[FIFO_ADDR_WIDTH-1:0]] <= {s_axis_tlast, s_axis_tdata};
        if (load) {out_last, out_data} <= mem[rd_ptr[FIFO_ADDR_WIDTH-1:0]];
    end

    assign m.tdata  = out_data;
    assign m.tlast  = out_last;
    assign m.tvalid = out_valid && drain_en;           // Held beat stays put when disabled

endmodule

// ==== verilog/axis_ll_bridge.sv ====
`timescale 1ns/1ps

module axis_ll_bridge #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    axis_if.sink                  s,
    output logic [DATA_WIDTH-1:0] ll_data,
    output logic                  ll_sof_n,
    output logic                  ll_eof_n,
    output logic                  ll_src_rdy_n,
    input  logic                  ll_dst_rdy_n,
    output logic                  discard
);

    logic prev_last;                                   // Previous transferred beat was last
    logic single;                                      // Beat is a one-beat packet
    logic frame_vld;                                   // Beat goes out on LocalLink

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prev_last <= 1'b1;                         // Next beat starts a packet
        end else if (s.tvalid && s.tready) begin
            prev_last <= s.tlast;
        end
    end

    // SOF and EOF cannot share a beat, so one-beat packets are dropped
    assign single    = s.tvalid && s.tlast && prev_last;
    assign frame_vld = s.tvalid && !single;

    assign s.tready = !ll_dst_rdy_n;                   // Back-pressure straight through
    assign discard  = single && s.tready;              // Pulse when the dropped beat leaves

    assign ll_data      = s.tdata;
    assign ll_sof_n     = !(frame_vld && prev_last);
    assign ll_eof_n     = !(frame_vld && s.tlast);
    assign ll_src_rdy_n = !frame_vld;

endmodule

// ==== verilog/ll_stats.sv ====
`timescale 1ns/1ps

module ll_stats (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ll_eof_n,
    input  logic                 ll_src_rdy_n,
    input  logic                 ll_dst_rdy_n,
    input  logic                 discard,
    output ll_port_pkg::count_t  frames,
    output ll_port_pkg::count_t  drops
);

    logic ll_xfer;                                     // LocalLink beat moves
    logic frame_done;                                  // Last beat of a frame moves

    assign ll_xfer    = !ll_src_rdy_n && !ll_dst_rdy_n;
    assign frame_done = ll_xfer && !ll_eof_n;

    // **************************************************
    // Counters wrapping at 2^32
    // **************************************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            frames <= '0;
        end else if (frame_done) begin
            frames <= frames + 1'b1;                   // One per completed frame
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            drops <= '0;
        end else if (discard) begin
            drops <= drops + 1'b1;                     // One per dropped beat
        end
    end

endmodule

// ==== axil_regs/axil_regs.sv ====
`timescale 1ns/1ps

module axil_regs #(
    parameter int FIFO_ADDR_WIDTH = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  ll_port_pkg::axil_addr_t    s_axil_awaddr,
    input  logic                       s_axil_awvalid,
    output logic                       s_axil_awready,
    input  ll_port_pkg::axil_data_t    s_axil_wdata,
    input  logic                       s_axil_wvalid,
    output logic                       s_axil_wready,
    output logic                       s_axil_bvalid,
    input  logic                       s_axil_bready,
    input  ll_port_pkg::axil_addr_t    s_axil_araddr,
    input  logic                       s_axil_arvalid,
    output logic                       s_axil_arready,
    output ll_port_pkg::axil_data_t    s_axil_rdata,
    output logic                       s_axil_rvalid,
    input  logic                       s_axil_rready,
    input  logic [FIFO_ADDR_WIDTH:0]   level,
    input  ll_port_pkg::count_t        frames,
    input  ll_port_pkg::count_t        drops,
    output logic                       drain_en
);

    ll_port_pkg::regs_state_t state;
    ll_port_pkg::axil_data_t  rd_word;                 // Read mux output
    logic                     ctrl_en;                 // CTRL bit 0

    // **************************************************
    // Read mux
    // **************************************************
    always_comb begin
        case (s_axil_araddr)
            ll_port_pkg::REG_ID:     rd_word = ll_port_pkg::ID_VALUE;
            ll_port_pkg::REG_CTRL:   rd_word = {31'd0, ctrl_en};
            ll_port_pkg::REG_LEVEL:  rd_word = ll_port_pkg::axil_data_t'(level);
            ll_port_pkg::REG_FRAMES: rd_word = frames;
            ll_port_pkg::REG_DROPS:  rd_word = drops;
            default:                 rd_word = '0;    // Unmapped reads as zero
        endcase
    end

    // **************************************************
    // Transaction FSM
    // **************************************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state          <= ll_port_pkg::ST_IDLE;
            s_axil_awready <= 1'b0;
            s_axil_wready  <= 1'b0;
            s_axil_bvalid  <= 1'b0;
            s_axil_arready <= 1'b0;
            s_axil_rvalid  <= 1'b0;
            ctrl_en        <= 1'b1;                    // Draining on by default
        end else begin
            case (state)
                ll_port_pkg::ST_IDLE: begin
                    if (s_axil_awready) begin
                        s_axil_awready <= 1'b0;        // Handshake done this edge
                        s_axil_wready  <= 1'b0;
                        s_axil_bvalid  <= 1'b1;
                        state          <= ll_port_pkg::ST_WRESP;
                        if (s_axil_awaddr == ll_port_pkg::REG_CTRL) begin
                            ctrl_en <= s_axil_wdata[0];
                        end
                    end else if (s_axil_arready) begin
                        s_axil_arready <= 1'b0;
                        s_axil_rvalid  <= 1'b1;
                        state          <= ll_port_pkg::ST_RDATA;
                    end else if (s_axil_awvalid && s_axil_wvalid) begin
                        s_axil_awready <= 1'b1;        // Write wins a tie
                        s_axil_wready  <= 1'b1;
                    end else if (s_axil_arvalid) begin
                        s_axil_arready <= 1'b1;
                    end
                end
                ll_port_pkg::ST_WRESP: begin
                    if (s_axil_bready) begin
                        s_axil_bvalid <= 1'b0;
                        state         <= ll_port_pkg::ST_IDLE;
                    end
                end
                ll_port_pkg::ST_RDATA: begin
                    if (s_axil_rready) begin
                        s_axil_rvalid <= 1'b0;
                        state         <= ll_port_pkg::ST_IDLE;
                    end
                end
                default: state <= ll_port_pkg::ST_IDLE;
            endcase
        end
    end

    // Read data held with rvalid
    always_ff @(posedge clk) begin
        if (state == ll_port_pkg::ST_IDLE && s_axil_arready && !s_axil_awready) begin
            s_axil_rdata <= rd_word;
        end
    end

    assign drain_en = ctrl_en;

endmodule

// ==== verilog/ll_port_top.sv ====
`timescale 1ns/1ps

module ll_port_top #(
    parameter int DATA_WIDTH      = 8,
    parameter int FIFO_ADDR_WIDTH = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [DATA_WIDTH-1:0]   s_axis_tdata,
    input  logic                    s_axis_tvalid,
    input  logic                    s_axis_tlast,
    output logic                    s_axis_tready,
    output logic [DATA_WIDTH-1:0]   ll_data,
    output logic                    ll_sof_n,
    output logic                    ll_eof_n,
    output logic                    ll_src_rdy_n,
    input  logic                    ll_dst_rdy_n,
    input  ll_port_pkg::axil_addr_t s_axil_awaddr,
    input  logic                    s_axil_awvalid,
    input  ll_port_pkg::axil_data_t s_axil_wdata,
    input  logic                    s_axil_wvalid,
    input  logic                    s_axil_bready,
    input  ll_port_pkg::axil_addr_t s_axil_araddr,
    input  logic                    s_axil_arvalid,
    input  logic                    s_axil_rready,
    output logic                    s_axil_awready,
    output logic                    s_axil_wready,
    output logic                    s_axil_bvalid,
    output logic                    s_axil_arready,
    output ll_port_pkg::axil_data_t s_axil_rdata,
    output logic                    s_axil_rvalid
);

    logic [FIFO_ADDR_WIDTH:0] level;                   // FIFO fill level
    logic                     drain_en;
    logic                     discard;                 // Dropped one-beat packet
    ll_port_pkg::count_t      frames;
    ll_port_pkg::count_t      drops;

    axis_if #(.DATA_WIDTH(DATA_WIDTH)) fifo_out ();   // FIFO to bridge

    axil_regs #(.FIFO_ADDR_WIDTH(FIFO_ADDR_WIDTH)) u_axil_regs (
        .clk, .rst,
        .s_axil_awaddr, .s_axil_awvalid, .s_axil_awready,
        .s_axil_wdata, .s_axil_wvalid, .s_axil_wready,
        .s_axil_bvalid, .s_axil_bready,
        .s_axil_araddr, .s_axil_arvalid, .s_axil_arready,
        .s_axil_rdata, .s_axil_rvalid, .s_axil_rready,
        .level, .frames, .drops, .drain_en
    );

    axis_fifo #(.DATA_WIDTH(DATA_WIDTH), .FIFO_ADDR_WIDTH(FIFO_ADDR_WIDTH)) u_axis_fifo (
        .clk, .rst,
        .s_axis_tdata, .s_axis_tvalid, .s_axis_tlast, .s_axis_tready,
        .m(fifo_out.src),
        .drain_en, .level
    );

    axis_ll_bridge #(.DATA_WIDTH(DATA_WIDTH)) u_axis_ll_bridge (
        .clk, .rst,
        .s(fifo_out.sink),
        .ll_data, .ll_sof_n, .ll_eof_n, .ll_src_rdy_n, .ll_dst_rdy_n,
        .discard
    );

    ll_stats u_ll_stats (
        .clk, .rst,
        .ll_eof_n, .ll_src_rdy_n, .ll_dst_rdy_n,
        .discard, .frames, .drops
    );

endmodule

// ==== bench/ll_port_assert.sv ====
`timescale 1ns/1ps

module ll_port_assert #(
    parameter int DATA_WIDTH = 8
) (
    input logic                  clk,
    input logic                  rst,
    input logic [DATA_WIDTH-1:0] s_axis_tdata,
    input logic                  s_axis_tvalid,
    input logic                  s_axis_tready,
    input logic                  ll_sof_n,
    input logic                  ll_eof_n,
    input logic                  ll_src_rdy_n,
    input logic                  s_axil_bvalid,
    input logic                  s_axil_bready,
    input logic                  s_axil_rvalid,
    input logic                  s_axil_rready
);

    // Framing flags idle when no beat is offered
    a_ll_idle_flags: assert property (@(posedge clk) disable iff (rst)
        ll_src_rdy_n |-> (ll_sof_n && ll_eof_n))
        else $error("LocalLink sof_n or eof_n low without src_rdy_n");

    // Stalled input beat keeps its payload
    a_axis_stable: assert property (@(posedge clk) disable iff (rst)
        (s_axis_tvalid && !s_axis_tready) |=> $stable(s_axis_tdata))
        else $error("s_axis_tdata changed while stalled");

    // **************************************************
    // AXI4-Lite response holding
    // **************************************************
    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        (s_axil_bvalid && !s_axil_bready) |=> s_axil_bvalid)
        else $error("bvalid dropped before bready");

    a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        (s_axil_rvalid && !s_axil_rready) |=> s_axil_rvalid)
        else $error("rvalid dropped before rready");

endmodule

bind ll_port_top ll_port_assert #(.DATA_WIDTH(DATA_WIDTH)) u_ll_port_assert (
    .clk(clk), .rst(rst),
    .s_axis_tdata(s_axis_tdata), .s_axis_tvalid(s_axis_tvalid), .s_axis_tready(s_axis_tready),
    .ll_sof_n(ll_sof_n), .ll_eof_n(ll_eof_n), .ll_src_rdy_n(ll_src_rdy_n),
    .s_axil_bvalid(s_axil_bvalid), .s_axil_bready(s_axil_bready),
    .s_axil_rvalid(s_axil_rvalid), .s_axil_rready(s_axil_rready)
);

// ==== bench/tb_ll_port.sv ====
`timescale 1ns/1ps

module tb_ll_port;

    localparam int DATA_WIDTH      = 8;
    localparam int FIFO_ADDR_WIDTH = 4;
    localparam int TIMEOUT         = 1000;             // Cycles per wait

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic                  sof;
        logic                  eof;
    } beat_t;

    logic                    clk;
    logic                    rst;
    logic [DATA_WIDTH-1:0]   s_axis_tdata;
    logic                    s_axis_tvalid;
    logic                    s_axis_tlast;
    logic                    s_axis_tready;
    logic [DATA_WIDTH-1:0]   ll_data;
    logic                    ll_sof_n;
    logic                    ll_eof_n;
    logic                    ll_src_rdy_n;
    logic                    ll_dst_rdy_n;
    ll_port_pkg::axil_addr_t s_axil_awaddr;
    logic                    s_axil_awvalid;
    ll_port_pkg::axil_data_t s_axil_wdata;
    logic                    s_axil_wvalid;
    logic                    s_axil_bready;
    ll_port_pkg::axil_addr_t s_axil_araddr;
    logic                    s_axil_arvalid;
    logic                    s_axil_rready;
    logic                    s_axil_awready;
    logic                    s_axil_wready;
    logic                    s_axil_bvalid;
    logic                    s_axil_arready;
    ll_port_pkg::axil_data_t s_axil_rdata;
    logic                    s_axil_rvalid;

    integer seed = 32'h9792_93c2;
    beat_t  exp_q[$];                                  // Beats expected on LocalLink
    int     frames_exp;                                // Model multi-beat packets
    int     drops_exp;                                 // Model single-beat packets
    int     errors;
    int     xfer_count;                                // LocalLink beats seen
    int     tests_run;
    int     tests_failed;
    int     test_err0;
    logic   bp_on;                                     // Random back-pressure on
    ll_port_pkg::axil_data_t rd;
    int     n;
    int     xfer_before;

    ll_port_top #(.DATA_WIDTH(DATA_WIDTH), .FIFO_ADDR_WIDTH(FIFO_ADDR_WIDTH)) u_ll_port_top (.*);

    always #50 clk = ~clk;

    // Back-pressure busy about 30 percent of cycles
    always @(posedge clk) begin
        logic busy;
        busy = ($unsigned($random(seed)) % 100) < 30;
        #1;
        if (bp_on) ll_dst_rdy_n = busy;
        else ll_dst_rdy_n = 1'b0;
    end

    // **************************************************
    // LocalLink monitor sampled mid-cycle
    // **************************************************
    always @(negedge clk) begin
        beat_t want;
        if (!rst && !ll_src_rdy_n && !ll_dst_rdy_n) begin
            xfer_count++;
            if (exp_q.size() == 0) begin
                $display("unexpected LocalLink beat with data 0x%h", ll_data);
                errors++;
            end else begin
                want = exp_q.pop_front();
                if (ll_data !== want.data) begin
                    $display("mismatch ll_data: got 0x%h expected 0x%h", ll_data, want.data);
                    errors++;
                end
                if (ll_sof_n !== !want.sof) begin
                    $display("mismatch ll_sof_n: got 0x%h expected 0x%h", ll_sof_n, !want.sof);
                    errors++;
                end
                if (ll_eof_n !== !want.eof) begin
                    $display("mismatch ll_eof_n: got 0x%h expected 0x%h", ll_eof_n, !want.eof);
                    errors++;
                end
            end
        end
    end

    // **************************************************
    // Bus tasks entered 1 ns after a rising edge
    // **************************************************
    task automatic send_beat(input logic [DATA_WIDTH-1:0] d, input logic last);
        int waited;
        waited        = 0;
        s_axis_tdata  = d;
        s_axis_tlast  = last;
        s_axis_tvalid = 1'b1;
        @(negedge clk);
        while (!s_axis_tready && waited < TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        if (!s_axis_tready) begin
            $display("timeout: the input stream never became ready");
            errors++;
        end
        @(posedge clk);                                // Beat taken here
        #1;
        s_axis_tvalid = 1'b0;
    endtask

    task automatic send_packet(input int len);
        beat_t           b;
        logic [DATA_WIDTH-1:0] d;
        int              gap;
        int              i;
        if (len == 1) drops_exp++;                     // Bridge drops it
        else frames_exp++;
        for (i = 0; i < len; i++) begin
            d = $random(seed);
            if (len > 1) begin
                b.data = d;
                b.sof  = (i == 0);
                b.eof  = (i == len - 1);
                exp_q.push_back(b);
            end
            send_beat(d, i == len - 1);
            gap = $unsigned($random(seed)) % 3;        // Idle cycles between beats
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic write_reg(input ll_port_pkg::axil_addr_t addr,
                             input ll_port_pkg::axil_data_t data);
        int waited;
        int stall;
        waited         = 0;
        s_axil_awaddr  = addr;
        s_axil_wdata   = data;
        s_axil_awvalid = 1'b1;
        s_axil_wvalid  = 1'b1;
        @(negedge clk);
        while (!(s_axil_awready && s_axil_wready) && waited < TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        if (!(s_axil_awready && s_axil_wready)) begin
            $display("timeout: register write address was never accepted");
            errors++;
        end
        @(posedge clk);
        #1;
        s_axil_awvalid = 1'b0;
        s_axil_wvalid  = 1'b0;
        stall          = $unsigned($random(seed)) % 3; // Response left waiting
        repeat (stall) begin
            @(posedge clk);
            #1;
        end
        s_axil_bready  = 1'b1;
        waited         = 0;
        @(negedge clk);
        while (!s_axil_bvalid && waited < TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        if (!s_axil_bvalid) begin
            $display("timeout: register write got no response");
            errors++;
        end
        @(posedge clk);                                // Response taken
        #1;
        s_axil_bready = 1'b0;
    endtask

    task automatic read_reg(input ll_port_pkg::axil_addr_t addr,
                            output ll_port_pkg::axil_data_t data);
        int waited;
        int stall;
        waited         = 0;
        data           = '0;
        s_axil_araddr  = addr;
        s_axil_arvalid = 1'b1;
        @(negedge clk);
        while (!s_axil_arready && waited < TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        if (!s_axil_arready) begin
            $display("timeout: register read address was never accepted");
            errors++;
        end
        @(posedge clk);
        #1;
        s_axil_arvalid = 1'b0;
        stall          = $unsigned($random(seed)) % 3; // Read data left waiting
        repeat (stall) begin
            @(posedge clk);
            #1;
        end
        s_axil_rready  = 1'b1;
        waited         = 0;
        @(negedge clk);
        while (!s_axil_rvalid && waited < TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        if (!s_axil_rvalid) begin
            $display("timeout: register read returned no data");
            errors++;
        end
        data = s_axil_rdata;
        @(posedge clk);
        #1;
        s_axil_rready = 1'b0;
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < TIMEOUT) begin
            waited++;
            @(posedge clk);
        end
        #1;
        if (exp_q.size() != 0) begin
            $display("timeout: %0d expected beats never left on LocalLink", exp_q.size());
            errors++;
        end
    endtask

    // Poll LEVEL so trailing dropped beats are gone too
    task automatic wait_level_zero();
        ll_port_pkg::axil_data_t lvl;
        int                      tries;
        tries = 0;
        read_reg(ll_port_pkg::REG_LEVEL, lvl);
        while (lvl != 0 && tries < 200) begin
            tries++;
            read_reg(ll_port_pkg::REG_LEVEL, lvl);
        end
        if (lvl != 0) begin
            $display("timeout: FIFO level never returned to zero");
            errors++;
        end
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (errors != test_err0) tests_failed++;
        $display("test %0d %s: %s", tests_run, name, (errors == test_err0) ? "ok" : "FAILED");
        test_err0 = errors;
    endtask

    // **************************************************
    // Test sequence
    // **************************************************
    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        s_axis_tdata   = '0;
        s_axis_tvalid  = 1'b0;
        s_axis_tlast   = 1'b0;
        ll_dst_rdy_n   = 1'b0;
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b0;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b0;
        bp_on          = 1'b0;
        frames_exp     = 0;
        drops_exp      = 0;
        errors         = 0;
        xfer_count     = 0;
        tests_run      = 0;
        tests_failed   = 0;
        test_err0      = 0;
        repeat (16) @(posedge clk);
        #1;
        if (s_axis_tready !== 1'b0) begin
            $display("mismatch s_axis_tready: got 0x%h expected 0x0", s_axis_tready);
            errors++;
        end
        rst = 1'b0;
        @(posedge clk);
        #1;

        // Reset state, ID and CTRL
        if (ll_src_rdy_n !== 1'b1) begin
            $display("mismatch ll_src_rdy_n: got 0x%h expected 0x1", ll_src_rdy_n);
            errors++;
        end
        if (s_axil_bvalid !== 1'b0) begin
            $display("mismatch s_axil_bvalid: got 0x%h expected 0x0", s_axil_bvalid);
            errors++;
        end
        if (s_axil_rvalid !== 1'b0) begin
            $display("mismatch s_axil_rvalid: got 0x%h expected 0x0", s_axil_rvalid);
            errors++;
        end
        read_reg(ll_port_pkg::REG_ID, rd);
        if (rd !== ll_port_pkg::ID_VALUE) begin
            $display("mismatch REG_ID: got 0x%h expected 0x%h", rd, ll_port_pkg::ID_VALUE);
            errors++;
        end
        write_reg(ll_port_pkg::REG_CTRL, 32'h0);
        read_reg(ll_port_pkg::REG_CTRL, rd);
        if (rd !== 32'h0) begin
            $display("mismatch REG_CTRL: got 0x%h expected 0x0", rd);
            errors++;
        end
        write_reg(ll_port_pkg::REG_CTRL, 32'h1);
        read_reg(ll_port_pkg::REG_CTRL, rd);
        if (rd !== 32'h1) begin
            $display("mismatch REG_CTRL: got 0x%h expected 0x1", rd);
            errors++;
        end
        close_test("reset and registers");

        bp_on = 1'b1;
        repeat (40) send_packet(2 + $unsigned($random(seed)) % 5);
        wait_drained();
        close_test("multi-beat packets");

        repeat (40) send_packet(1 + $unsigned($random(seed)) % 6);
        wait_drained();
        wait_level_zero();
        close_test("single-beat packets dropped");

        read_reg(ll_port_pkg::REG_FRAMES, rd);
        if (rd !== frames_exp) begin
            $display("mismatch REG_FRAMES: got 0x%h expected 0x%h", rd, frames_exp);
            errors++;
        end
        read_reg(ll_port_pkg::REG_DROPS, rd);
        if (rd !== drops_exp) begin
            $display("mismatch REG_DROPS: got 0x%h expected 0x%h", rd, drops_exp);
            errors++;
        end
        close_test("frame and drop counters");

        bp_on = 1'b0;                                  // Sink always ready
        write_reg(ll_port_pkg::REG_CTRL, 32'h0);
        n = 2 + $unsigned($random(seed)) % 5;
        xfer_before = xfer_count;
        send_packet(n);
        repeat (50) @(posedge clk);
        #1;
        if (xfer_count != xfer_before) begin
            $display("LocalLink moved %0d beats while draining was off", xfer_count - xfer_before);
            errors++;
        end
        read_reg(ll_port_pkg::REG_LEVEL, rd);
        if (rd !== n) begin
            $display("mismatch REG_LEVEL: got 0x%h expected 0x%h", rd, n);
            errors++;
        end
        write_reg(ll_port_pkg::REG_CTRL, 32'h1);
        wait_drained();
        read_reg(ll_port_pkg::REG_LEVEL, rd);
        if (rd !== 32'h0) begin
            $display("mismatch REG_LEVEL: got 0x%h expected 0x0", rd);
            errors++;
        end
        close_test("drain enable");

        $display("tests %0d, failed %0d, errors %0d, LocalLink beats %0d",
                 tests_run, tests_failed, errors, xfer_count);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
common/ll_port_pkg.sv
common/axis_if.sv
verilog/axis_fifo.sv
verilog/axis_ll_bridge.sv
verilog/ll_stats.sv
axil_regs/axil_regs.sv
verilog/ll_port_top.sv
bench/ll_port_assert.sv
bench/tb_ll_port.sv

// ==== Bender.yml ====
package:
  name: ll_port

sources:
  - common/ll_port_pkg.sv
  - common/axis_if.sv
  - verilog/axis_fifo.sv
  - verilog/axis_ll_bridge.sv
  - verilog/ll_stats.sv
  - axil_regs/axil_regs.sv
  - verilog/ll_port_top.sv
  - target: test
    files:
      - bench/ll_port_assert.sv
      - bench/tb_ll_port.sv
